/* design/mem_stage_pkg.sv */
package mem_stage_pkg;

  typedef logic [31:0] reg_data_t;
  typedef logic [4:0]  reg_addr_t;

  localparam int lsu_op_width = 3;

  // loads take the five low codes, stores the three top codes.
  typedef enum logic [lsu_op_width-1:0] {
    LB  = 3'd0,
    LH  = 3'd1,
    LW  = 3'd2,
    LBU = 3'd3,
    LHU = 3'd4,
    SB  = 3'd5,
    SH  = 3'd6,
    SW  = 3'd7
  } lsu_op_e;

  // one 64-bit data beat, seen as bytes, halfwords or words.
  typedef union packed {
    logic [7:0][7:0]  bytes;
    logic [3:0][15:0] halves;
    logic [1:0][31:0] words;
  } axi_beat_u;

  localparam logic [1:0] axi_resp_okay   = 2'b00;
  localparam logic [1:0] axi_resp_slverr = 2'b10;

  function automatic logic lsu_is_store(lsu_op_e op);
    return op inside {SB, SH, SW};
  endfunction

endpackage

/* design/lsu_bus_if.sv */
`timescale 1ns/10ps

interface lsu_bus_if (
  input logic clk,
  input logic rst_n
);

  logic                     req_valid;
  logic                     req_write;
  logic [31:0]              req_addr;
  mem_stage_pkg::axi_beat_u req_wdata;
  logic [7:0]               req_wstrb;
  logic                     req_ready;
  logic                     resp_valid;
  mem_stage_pkg::axi_beat_u resp_rdata;
  logic                     resp_err;

  modport stage (
    output req_valid,
    output req_write,
    output req_addr,
    output req_wdata,
    output req_wstrb,
    input  req_ready,
    input  resp_valid,
    input  resp_rdata,
    input  resp_err
  );

  modport master (
    input  req_valid,
    input  req_write,
    input  req_addr,
    input  req_wdata,
    input  req_wstrb,
    output req_ready,
    output resp_valid,
    output resp_rdata,
    output resp_err
  );

  // a stalled request keeps its fields until the master takes it.
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid && !req_ready |=> req_valid && $stable(req_addr) && $stable(req_write)
      && $stable(req_wdata) && $stable(req_wstrb));

  // one response pulse per request.
  a_resp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid |=> !resp_valid);

endinterface

/* design/lsu_align.sv */
`timescale 1ns/10ps

module lsu_align (
  input  mem_stage_pkg::lsu_op_e   lsu_op,
  input  logic [2:0]               addr_low,
  input  mem_stage_pkg::reg_data_t store_data,
  input  mem_stage_pkg::axi_beat_u rdata,
  output mem_stage_pkg::axi_beat_u wdata,
  output logic [7:0]               wstrb,
  output mem_stage_pkg::reg_data_t load_data,
  output logic                     misaligned
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;
  logic [31:0] word_sel;
  logic        is_store;

  assign is_store = mem_stage_pkg::lsu_is_store(lsu_op);
  assign byte_sel = rdata.bytes[addr_low];
  assign half_sel = rdata.halves[addr_low[2:1]];
  assign word_sel = rdata.words[addr_low[2]];

  always_comb begin
    case (lsu_op)
      mem_stage_pkg::LH, mem_stage_pkg::LHU, mem_stage_pkg::SH: misaligned = addr_low[0];
      mem_stage_pkg::LW, mem_stage_pkg::SW: misaligned = (addr_low[1:0] != 2'b00);
      default: misaligned = 1'b0;
    endcase
  end

  // ============================================================
  // store side
  // ============================================================
  always_comb begin
    wdata = '0;
    wstrb = 8'h00;
    case (lsu_op)
      mem_stage_pkg::SB: begin
        wdata.bytes = {8{store_data[7:0]}};
        wstrb       = 8'h01 << addr_low;
      end
      mem_stage_pkg::SH: begin
        wdata.halves = {4{store_data[15:0]}};
        wstrb        = 8'h03 << {addr_low[2:1], 1'b0};
      end
      mem_stage_pkg::SW: begin
        wdata.words = {2{store_data}};
        wstrb       = 8'h0f << {addr_low[2], 2'b00};
      end
      default: wstrb = 8'h00;
    endcase
    // no lane gets written for a misaligned store.
    if (misaligned) begin
      wstrb = 8'h00;
    end
  end

  // ============================================================
  // load side
  // ============================================================
  always_comb begin
    case (lsu_op)
      mem_stage_pkg::LB:  load_data = {{24{byte_sel[7]}}, byte_sel};
      mem_stage_pkg::LBU: load_data = {24'h000000, byte_sel};
      mem_stage_pkg::LH:  load_data = {{16{half_sel[15]}}, half_sel};
      mem_stage_pkg::LHU: load_data = {16'h0000, half_sel};
      default:            load_data = word_sel;
    endcase
  end

  always_comb begin
    if (is_store && !misaligned) begin
      a_store_strobe: assert (wstrb != 8'h00)
        else $error("aligned store produced an empty strobe");
    end
  end

endmodule

/* design/axi_lsu_master.sv */
`timescale 1ns/10ps

module axi_lsu_master #(
  parameter logic [2:0] bus_prot = 3'b000
) (
  input  logic        clk,
  input  logic        rst_n,
  lsu_bus_if.master   bus,

  output logic        awid,
  output logic [31:0] awaddr,
  output logic [7:0]  awlen,
  output logic [2:0]  awsize,
  output logic [1:0]  awburst,
  output logic        awlock,
  output logic [3:0]  awcache,
  output logic [2:0]  awprot,
  output logic        awvalid,
  output logic [3:0]  awregion,
  output logic [3:0]  awqos,
  input  logic        awready,

  output logic [63:0] wdata,
  output logic [7:0]  wstrb,
  output logic        wlast,
  output logic        wvalid,
  input  logic        wready,

  input  logic        bid,
  input  logic [1:0]  bresp,
  input  logic        bvalid,
  output logic        bready,

  output logic        arid,
  output logic [31:0] araddr,
  output logic [7:0]  arlen,
  output logic [2:0]  arsize,
  output logic [1:0]  arburst,
  output logic        arlock,
  output logic [3:0]  arcache,
  output logic [2:0]  arprot,
  output logic        arvalid,
  output logic [3:0]  arqos,
  output logic [3:0]  arregion,
  input  logic        arready,

  input  logic        rid,
  input  logic [63:0] rdata,
  input  logic [1:0]  rresp,
  input  logic        rlast,
  input  logic        rvalid,
  output logic        rready
);

  typedef enum logic [2:0] {
    st_idle,
    st_wr,
    st_wr_resp,
    st_rd_addr,
    st_rd_data
  } state_e;

  state_e      state_q;
  state_e      state_d;
  logic [28:0] beat_addr_q;
  logic [63:0] wdata_q;
  logic [7:0]  wstrb_q;
  logic        aw_done_q;
  logic        w_done_q;
  logic        req_fire;
  logic        aw_fire;
  logic        w_fire;

  assign req_fire = bus.req_valid && bus.req_ready;
  assign aw_fire  = awvalid && awready;
  assign w_fire   = wvalid && wready;

  // aw and w may complete in either order.
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (req_fire) begin
          state_d = bus.req_write ? st_wr : st_rd_addr;
        end
      end
      st_wr: begin
        if ((aw_done_q || aw_fire) && (w_done_q || w_fire)) begin
          state_d = st_wr_resp;
        end
      end
      st_wr_resp: begin
        if (bvalid) begin
          state_d = st_idle;
        end
      end
      st_rd_addr: begin
        if (arready) begin
          state_d = st_rd_data;
        end
      end
      st_rd_data: begin
        if (rvalid) begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= st_idle;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_d != st_wr) begin
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
      end else begin
        if (aw_fire) begin
          aw_done_q <= 1'b1;
        end
        if (w_fire) begin
          w_done_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      beat_addr_q <= bus.req_addr[31:3];
      wdata_q     <= bus.req_wdata;
      wstrb_q     <= bus.req_wstrb;
    end
  end

  assign bus.req_ready  = (state_q == st_idle);
  assign bus.resp_valid = ((state_q == st_wr_resp) && bvalid) ||
                          ((state_q == st_rd_data) && rvalid);
  assign bus.resp_err   = (state_q == st_wr_resp) ? (bresp != mem_stage_pkg::axi_resp_okay)
                                                  : (rresp != mem_stage_pkg::axi_resp_okay);
  assign bus.resp_rdata = rdata;

  // single beat of 8 bytes, id 0, incr burst.
  assign awid     = 1'b0;
  assign awaddr   = {beat_addr_q, 3'b000};
  assign awlen    = 8'd0;
  assign awsize   = 3'd3;
  assign awburst  = 2'b01;
  assign awlock   = 1'b0;
  assign awcache  = 4'b0000;
  assign awprot   = bus_prot;
  assign awvalid  = (state_q == st_wr) && !aw_done_q;
  assign awregion = 4'd0;
  assign awqos    = 4'd0;

  assign wdata  = wdata_q;
  assign wstrb  = wstrb_q;
  assign wlast  = 1'b1;
  assign wvalid = (state_q == st_wr) && !w_done_q;
  assign bready = (state_q == st_wr_resp);

  assign arid     = 1'b0;
  assign araddr   = {beat_addr_q, 3'b000};
  assign arlen    = 8'd0;
  assign arsize   = 3'd3;
  assign arburst  = 2'b01;
  assign arlock   = 1'b0;
  assign arcache  = 4'b0000;
  assign arprot   = bus_prot;
  assign arvalid  = (state_q == st_rd_addr);
  assign arqos    = 4'd0;
  assign arregion = 4'd0;
  assign rready   = (state_q == st_rd_data);

  a_aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
    awvalid && !awready |=> awvalid && $stable(awaddr));

  a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable(araddr));

  a_r_single: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid |-> rlast && (rid == 1'b0));

  a_b_id: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid |-> (bid == 1'b0));

endmodule

/* design/mem_stage.sv */
`timescale 1ns/10ps

module mem_stage (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     m_valid,
  output logic                     m_ready,
  input  logic                     lsu_m,
  input  mem_stage_pkg::lsu_op_e   lsu_op_m,
  input  mem_stage_pkg::reg_data_t alu_res_m,
  input  mem_stage_pkg::reg_data_t store_data_m,
  input  mem_stage_pkg::reg_addr_t rd_addr_m,
  input  logic                     rd_en_m,
  lsu_bus_if.stage                 bus,
  output logic                     wb_valid,
  output logic                     rd_en_wb,
  output mem_stage_pkg::reg_addr_t rd_addr_wb,
  output mem_stage_pkg::reg_data_t rd_data_wb,
  output logic                     exc_wb
);

  mem_stage_pkg::lsu_op_e   op_q;
  mem_stage_pkg::reg_addr_t rd_addr_q;
  logic                     rd_en_q;
  logic                     busy_q;
  logic                     req_valid_q;
  mem_stage_pkg::reg_data_t req_addr_q;
  mem_stage_pkg::axi_beat_u req_wdata_q;
  logic [7:0]               req_wstrb_q;
  mem_stage_pkg::lsu_op_e   align_op;
  logic [2:0]               align_low;
  mem_stage_pkg::axi_beat_u align_wdata;
  logic [7:0]               align_wstrb;
  mem_stage_pkg::reg_data_t load_data;
  logic                     misaligned;
  logic                     accept;
  logic                     issue;

  // the aligner checks the incoming op while idle and the held op while busy.
  assign align_op  = busy_q ? op_q : lsu_op_m;
  assign align_low = busy_q ? req_addr_q[2:0] : alu_res_m[2:0];

  lsu_align u_align (
    .lsu_op     (align_op),
    .addr_low   (align_low),
    .store_data (store_data_m),
    .rdata      (bus.resp_rdata),
    .wdata      (align_wdata),
    .wstrb      (align_wstrb),
    .load_data  (load_data),
    .misaligned (misaligned)
  );

  assign m_ready = !busy_q;
  assign accept  = m_valid && m_ready;
  assign issue   = accept && lsu_m && !misaligned;

  assign bus.req_valid = req_valid_q;
  assign bus.req_write = mem_stage_pkg::lsu_is_store(op_q);
  assign bus.req_addr  = req_addr_q;
  assign bus.req_wdata = req_wdata_q;
  assign bus.req_wstrb = req_wstrb_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q      <= 1'b0;
      req_valid_q <= 1'b0;
      wb_valid    <= 1'b0;
      rd_en_wb    <= 1'b0;
      exc_wb      <= 1'b0;
    end else begin
      wb_valid <= 1'b0;
      rd_en_wb <= 1'b0;
      exc_wb   <= 1'b0;
      if (issue) begin
        busy_q      <= 1'b1;
        req_valid_q <= 1'b1;
      end else if (accept) begin
        // non-memory op, or a misaligned access that retires at once.
        wb_valid <= 1'b1;
        rd_en_wb <= rd_en_m && !lsu_m;
        exc_wb   <= lsu_m;
      end
      if (bus.req_valid && bus.req_ready) begin
        req_valid_q <= 1'b0;
      end
      if (bus.resp_valid) begin
        busy_q   <= 1'b0;
        wb_valid <= 1'b1;
        rd_en_wb <= rd_en_q && !mem_stage_pkg::lsu_is_store(op_q) && !bus.resp_err;
        exc_wb   <= bus.resp_err;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      op_q        <= lsu_op_m;
      rd_addr_q   <= rd_addr_m;
      rd_en_q     <= rd_en_m;
      req_addr_q  <= alu_res_m;
      req_wdata_q <= align_wdata;
      req_wstrb_q <= align_wstrb;
    end
    if (accept && !issue) begin
      rd_addr_wb <= rd_addr_m;
      rd_data_wb <= alu_res_m;
    end
    if (bus.resp_valid) begin
      rd_addr_wb <= rd_addr_q;
      rd_data_wb <= load_data;
    end
  end

  a_no_accept_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (busy_q || bus.req_valid) |-> !(m_valid && m_ready));

endmodule

/* design/mem_subsys_top.sv */
`timescale 1ns/10ps

module mem_subsys_top #(
  parameter logic [2:0] bus_prot = 3'b000
) (
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic                     m_valid,
  output logic                     m_ready,
  input  logic                     lsu_m,
  input  mem_stage_pkg::lsu_op_e   lsu_op_m,
  input  mem_stage_pkg::reg_data_t alu_res_m,
  input  mem_stage_pkg::reg_data_t store_data_m,
  input  mem_stage_pkg::reg_addr_t rd_addr_m,
  input  logic                     rd_en_m,

  output logic                     wb_valid,
  output logic                     rd_en_wb,
  output mem_stage_pkg::reg_addr_t rd_addr_wb,
  output mem_stage_pkg::reg_data_t rd_data_wb,
  output logic                     exc_wb,

  output logic                     awid,
  output logic [31:0]              awaddr,
  output logic [7:0]               awlen,
  output logic [2:0]               awsize,
  output logic [1:0]               awburst,
  output logic                     awlock,
  output logic [3:0]               awcache,
  output logic [2:0]               awprot,
  output logic                     awvalid,
  output logic [3:0]               awregion,
  output logic [3:0]               awqos,
  input  logic                     awready,

  output logic [63:0]              wdata,
  output logic [7:0]               wstrb,
  output logic                     wlast,
  output logic                     wvalid,
  input  logic                     wready,

  input  logic                     bid,
  input  logic [1:0]               bresp,
  input  logic                     bvalid,
  output logic                     bready,

  output logic                     arid,
  output logic [31:0]              araddr,
  output logic [7:0]               arlen,
  output logic [2:0]               arsize,
  output logic [1:0]               arburst,
  output logic                     arlock,
  output logic [3:0]               arcache,
  output logic [2:0]               arprot,
  output logic                     arvalid,
  output logic [3:0]               arqos,
  output logic [3:0]               arregion,
  input  logic                     arready,

  input  logic                     rid,
  input  logic [63:0]              rdata,
  input  logic [1:0]               rresp,
  input  logic                     rlast,
  input  logic                     rvalid,
  output logic                     rready
);

  lsu_bus_if bus (
    .clk   (clk),
    .rst_n (rst_n)
  );

  // pipeline and writeback ports share names with the top level.
  mem_stage u_stage (
    .bus (bus.stage),
    .*
  );

  axi_lsu_master #(
    .bus_prot (bus_prot)
  ) u_master (
    .bus (bus.master),
    .*
  );

endmodule

/* verif/mem_subsys_tb.sv */
`timescale 1ns/10ps

module mem_subsys_tb;

  localparam int         num_lines      = 25;
  localparam int         num_fields     = 11;
  localparam int         timeout_cycles = num_lines * 20 + 50;
  localparam logic [2:0] bus_prot       = 3'b010;

  logic                     clk;
  logic                     rst_n;
  logic                     m_valid;
  logic                     m_ready;
  logic                     lsu_m;
  mem_stage_pkg::lsu_op_e   lsu_op_m;
  mem_stage_pkg::reg_data_t alu_res_m;
  mem_stage_pkg::reg_data_t store_data_m;
  mem_stage_pkg::reg_addr_t rd_addr_m;
  logic                     rd_en_m;
  logic                     wb_valid;
  logic                     rd_en_wb;
  mem_stage_pkg::reg_addr_t rd_addr_wb;
  mem_stage_pkg::reg_data_t rd_data_wb;
  logic                     exc_wb;
  logic                     awid;
  logic [31:0]              awaddr;
  logic [7:0]               awlen;
  logic [2:0]               awsize;
  logic [1:0]               awburst;
  logic                     awlock;
  logic [3:0]               awcache;
  logic [2:0]               awprot;
  logic                     awvalid;
  logic [3:0]               awregion;
  logic [3:0]               awqos;
  logic                     awready;
  logic [63:0]              wdata;
  logic [7:0]               wstrb;
  logic                     wlast;
  logic                     wvalid;
  logic                     wready;
  logic                     bid;
  logic [1:0]               bresp;
  logic                     bvalid;
  logic                     bready;
  logic                     arid;
  logic [31:0]              araddr;
  logic [7:0]               arlen;
  logic [2:0]               arsize;
  logic [1:0]               arburst;
  logic                     arlock;
  logic [3:0]               arcache;
  logic [2:0]               arprot;
  logic                     arvalid;
  logic [3:0]               arqos;
  logic [3:0]               arregion;
  logic                     arready;
  logic                     rid;
  logic [63:0]              rdata;
  logic [1:0]               rresp;
  logic                     rlast;
  logic                     rvalid;
  logic                     rready;

  logic [31:0] trace_mem [num_lines * num_fields];
  logic [63:0] mem [64];
  integer      seed = 32'h1761_01cc;
  int          cycles;
  int          checks;
  int          errors;
  int          issue_idx;
  int          retire_idx;
  int          accept_cyc [num_lines];
  int          beats;
  int          beats_at_accept;
  int          exp_beats_total;
  logic        ready_seen;
  logic        cur_err;

  mem_subsys_top #(
    .bus_prot (bus_prot)
  ) dut (
    .*
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout after %0d cycles, %0d of %0d instructions retired",
               cycles, retire_idx, num_lines);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ============================================================
  // compare tasks and helpers
  // ============================================================
  task automatic check_data(string name, mem_stage_pkg::reg_data_t got,
                            mem_stage_pkg::reg_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(string name, mem_stage_pkg::reg_addr_t got,
                            mem_stage_pkg::reg_addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  function automatic int draw_delay();
    return $unsigned($random(seed)) % 4;
  endfunction

  task automatic drive_line(int idx);
    int base;
    base         = idx * num_fields;
    m_valid      = 1'b1;
    lsu_m        = trace_mem[base][0];
    lsu_op_m     = mem_stage_pkg::lsu_op_e'(trace_mem[base+1][2:0]);
    alu_res_m    = trace_mem[base+2];
    store_data_m = trace_mem[base+3];
    rd_addr_m    = trace_mem[base+4][4:0];
    rd_en_m      = trace_mem[base+5][0];
  endtask

  task automatic retire_line(int idx);
    int                     base;
    int                     errs_before;
    int                     exp_beats;
    logic                   is_mem;
    logic                   quick;
    string                  kind;
    mem_stage_pkg::lsu_op_e op;
    base        = idx * num_fields;
    errs_before = errors;
    op          = mem_stage_pkg::lsu_op_e'(trace_mem[base+1][2:0]);
    is_mem      = trace_mem[base][0];
    // alu ops and misaligned accesses (exc without an injected error) need no bus beat.
    quick       = !is_mem || (trace_mem[base+10][0] && !trace_mem[base+6][0]);
    exp_beats   = quick ? 0 : 1;
    exp_beats_total += exp_beats;
    check_bit("rd_en_wb", rd_en_wb, trace_mem[base+7][0]);
    check_bit("exc_wb", exc_wb, trace_mem[base+10][0]);
    if (trace_mem[base+7][0]) begin
      check_addr("rd_addr_wb", rd_addr_wb, trace_mem[base+8][4:0]);
      check_data("rd_data_wb", rd_data_wb, trace_mem[base+9]);
    end
    check_data("bus beats", beats - beats_at_accept, exp_beats);
    if (quick) begin
      check_data("retire cycle", cycles, accept_cyc[idx]);
    end
    if (is_mem) begin
      kind = op.name();
    end else begin
      kind = "alu";
    end
    $display("line %0d %s: %s", idx, kind, (errors == errs_before) ? "ok" : "error");
  endtask

  // ============================================================
  // AXI memory model
  // ============================================================
  initial begin
    int   aw_cnt;
    int   w_cnt;
    int   b_cnt;
    int   ar_cnt;
    int   r_cnt;
    logic have_aw;
    logic have_w;
    logic b_pend;
    logic r_pend;
    logic aw_v_q;
    logic w_v_q;
    logic ar_v_q;
    logic b_rdy_q;
    logic r_rdy_q;
    logic [5:0] rd_beat;
    awready = 1'b0;
    wready  = 1'b0;
    bid     = 1'b0;
    bresp   = mem_stage_pkg::axi_resp_okay;
    bvalid  = 1'b0;
    arready = 1'b0;
    rid     = 1'b0;
    rdata   = '0;
    rresp   = mem_stage_pkg::axi_resp_okay;
    rlast   = 1'b0;
    rvalid  = 1'b0;
    have_aw = 1'b0;
    have_w  = 1'b0;
    b_pend  = 1'b0;
    r_pend  = 1'b0;
    aw_v_q  = 1'b0;
    w_v_q   = 1'b0;
    ar_v_q  = 1'b0;
    b_rdy_q = 1'b0;
    r_rdy_q = 1'b0;
    rd_beat = '0;
    aw_cnt  = draw_delay();
    w_cnt   = draw_delay();
    b_cnt   = 0;
    ar_cnt  = draw_delay();
    r_cnt   = 0;
    // each byte takes its low address bits, top half flipped by address bit 8.
    for (int i = 0; i < 512; i++) begin
      mem[i / 8][(i % 8) * 8 +: 8] = i[7:0] ^ {i[8], 7'd0};
    end
    forever begin
      @(negedge clk);
      // handshakes of the rising edge just passed.
      if (aw_v_q && awready) begin
        awready = 1'b0;
        have_aw = 1'b1;
        aw_cnt  = draw_delay();
        beats++;
        check_data("awprot", {29'd0, awprot}, {29'd0, bus_prot});
        check_data("awaddr low bits", {29'd0, awaddr[2:0]}, 32'd0);
        check_bit("awid", awid, 1'b0);
        check_data("awlen", {24'd0, awlen}, 32'd0);
        check_data("awsize", {29'd0, awsize}, 32'd3);
        check_data("awburst", {30'd0, awburst}, 32'd1);
        check_data("awlock/awcache/awregion/awqos",
                   {19'd0, awlock, awcache, awregion, awqos}, 32'd0);
      end
      if (w_v_q && wready) begin
        wready = 1'b0;
        have_w = 1'b1;
        w_cnt  = draw_delay();
        check_bit("wlast", wlast, 1'b1);
      end
      if (have_aw && have_w) begin
        have_aw = 1'b0;
        have_w  = 1'b0;
        if (!cur_err) begin
          for (int b = 0; b < 8; b++) begin
            if (wstrb[b]) begin
              mem[awaddr[8:3]][b * 8 +: 8] = wdata[b * 8 +: 8];
            end
          end
        end
        b_pend = 1'b1;
        b_cnt  = draw_delay();
      end
      if (bvalid && b_rdy_q) begin
        bvalid = 1'b0;
      end
      if (b_pend) begin
        if (b_cnt == 0) begin
          bvalid = 1'b1;
          bresp  = cur_err ? mem_stage_pkg::axi_resp_slverr : mem_stage_pkg::axi_resp_okay;
          b_pend = 1'b0;
        end else begin
          b_cnt--;
        end
      end
      if (ar_v_q && arready) begin
        arready = 1'b0;
        rd_beat = araddr[8:3];
        ar_cnt  = draw_delay();
        r_pend  = 1'b1;
        r_cnt   = draw_delay();
        beats++;
        check_data("arprot", {29'd0, arprot}, {29'd0, bus_prot});
        check_data("araddr low bits", {29'd0, araddr[2:0]}, 32'd0);
        check_bit("arid", arid, 1'b0);
        check_data("arlen", {24'd0, arlen}, 32'd0);
        check_data("arsize", {29'd0, arsize}, 32'd3);
        check_data("arburst", {30'd0, arburst}, 32'd1);
        check_data("arlock/arcache/arregion/arqos",
                   {19'd0, arlock, arcache, arregion, arqos}, 32'd0);
      end
      if (rvalid && r_rdy_q) begin
        rvalid = 1'b0;
        rlast  = 1'b0;
      end
      if (r_pend) begin
        if (r_cnt == 0) begin
          rvalid = 1'b1;
          rlast  = 1'b1;
          rdata  = mem[rd_beat];
          rresp  = cur_err ? mem_stage_pkg::axi_resp_slverr : mem_stage_pkg::axi_resp_okay;
          r_pend = 1'b0;
        end else begin
          r_cnt--;
        end
      end
      if (awvalid && !awready && !have_aw) begin
        if (aw_cnt == 0) begin
          awready = 1'b1;
        end else begin
          aw_cnt--;
        end
      end
      if (wvalid && !wready && !have_w) begin
        if (w_cnt == 0) begin
          wready = 1'b1;
        end else begin
          w_cnt--;
        end
      end
      if (arvalid && !arready) begin
        if (ar_cnt == 0) begin
          arready = 1'b1;
        end else begin
          ar_cnt--;
        end
      end
      aw_v_q  = awvalid;
      w_v_q   = wvalid;
      ar_v_q  = arvalid;
      b_rdy_q = bready;
      r_rdy_q = rready;
    end
  end

  // ============================================================
  // trace driver and writeback checker
  // ============================================================
  initial begin
    $readmemh("verif/mem_trace.txt", trace_mem);
    rst_n        = 1'b0;
    m_valid      = 1'b0;
    lsu_m        = 1'b0;
    lsu_op_m     = mem_stage_pkg::LB;
    alu_res_m    = '0;
    store_data_m = '0;
    rd_addr_m    = '0;
    rd_en_m      = 1'b0;
    ready_seen   = 1'b0;
    cur_err      = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_bit("m_ready", m_ready, 1'b1);
    check_bit("wb_valid", wb_valid, 1'b0);
    check_bit("rd_en_wb", rd_en_wb, 1'b0);
    check_bit("exc_wb", exc_wb, 1'b0);
    check_bit("awvalid", awvalid, 1'b0);
    check_bit("wvalid", wvalid, 1'b0);
    check_bit("bready", bready, 1'b0);
    check_bit("arvalid", arvalid, 1'b0);
    check_bit("rready", rready, 1'b0);
    while (retire_idx < num_lines) begin
      @(negedge clk);
      // inputs and m_ready held since the last falling edge decide acceptance.
      if (m_valid && ready_seen) begin
        accept_cyc[issue_idx] = cycles;
        beats_at_accept       = beats;
        cur_err               = trace_mem[issue_idx * num_fields + 6][0];
        issue_idx++;
      end
      if (wb_valid) begin
        if (issue_idx == retire_idx) begin
          errors++;
          $display("writeback at %0t with no instruction in flight", $time);
        end else begin
          retire_line(retire_idx);
          retire_idx++;
        end
      end else if (issue_idx != retire_idx && m_ready) begin
        errors++;
        $display("m_ready high at %0t while line %0d is in flight", $time, retire_idx);
      end
      if (issue_idx < num_lines) begin
        drive_line(issue_idx);
      end else begin
        m_valid = 1'b0;
      end
      ready_seen = m_ready;
    end
    repeat (5) @(negedge clk);
    check_data("total bus beats", beats, exp_beats_total);
    $display("retired %0d of %0d instructions, %0d checks, %0d errors",
             retire_idx, num_lines, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* verif/mem_trace.txt */
// lsu op alu_res store_data rd_addr rd_en err, then expected rd_en rd_addr rd_data exc
// op codes 0 LB 1 LH 2 LW 3 LBU 4 LHU 5 SB 6 SH 7 SW; rd_addr and rd_data are unchecked when rd_en is 0
0 0 12345678 00000000 01 1 0 1 01 12345678 0
0 0 deadbeef 00000000 02 1 0 1 02 deadbeef 0
0 0 00000055 00000000 03 0 0 0 00 00000000 0
1 0 00000085 00000000 04 1 0 1 04 ffffff85 0
1 3 00000086 00000000 05 1 0 1 05 00000086 0
1 1 00000082 00000000 06 1 0 1 06 ffff8382 0
1 4 00000086 00000000 07 1 0 1 07 00008786 0
1 2 00000084 00000000 08 1 0 1 08 87868584 0
1 0 00000041 00000000 09 1 0 1 09 00000041 0
1 1 00000046 00000000 0a 1 0 1 0a 00004746 0
1 2 00000080 00000000 0b 1 0 1 0b 83828180 0
1 7 00000104 cafef00d 00 0 0 0 00 00000000 0
1 5 00000101 000000aa 00 0 0 0 00 00000000 0
1 6 00000106 00001234 00 0 0 0 00 00000000 0
1 2 00000100 00000000 0c 1 0 1 0c 8382aa80 0
1 2 00000104 00000000 0d 1 0 1 0d 1234f00d 0
1 4 00000100 00000000 0e 1 0 1 0e 0000aa80 0
1 2 00000102 00000000 0f 1 0 0 00 00000000 1
1 6 00000103 00005678 00 0 0 0 00 00000000 1
1 1 00000085 00000000 10 1 0 0 00 00000000 1
1 2 00000080 00000000 11 1 1 0 00 00000000 1
1 7 00000108 ffffffff 00 0 1 0 00 00000000 1
1 2 00000108 00000000 12 1 0 1 12 8b8a8988 0
0 2 0badcafe 00000000 13 1 0 1 13 0badcafe 0
1 0 000001ff 00000000 14 1 0 1 14 0000007f 0

/* verilog.f */
design/mem_stage_pkg.sv
design/lsu_bus_if.sv
design/lsu_align.sv
design/axi_lsu_master.sv
design/mem_stage.sv
design/mem_subsys_top.sv
verif/mem_subsys_tb.sv

/* Makefile */
TOOL     = verilator
TOP      = mem_subsys_tb
FILELIST = verilog.f
FLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0 --top-module $(TOP)
LOG      = sim.log
BIN      = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) -f $(FILELIST)

run: compile
	./$(BIN) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
